// File: Bender.yml
package:
  name: dbg_panel

sources:
  - design/dbg_cmd_pkg.sv
  - design/dbg_link_pkg.sv
  - design/dbg_scan.sv
  - design/dbg_print.sv
  - design/dbg_dispatch.sv
  - design/dbg_mem_dump.sv
  - design/dbg_cpu_view.sv
  - design/dbg_panel.sv
  - target: test
    files:
      - tests/tb_dbg_panel.sv

// File: design/dbg_cmd_pkg.sv
package dbg_cmd_pkg;

    localparam int unsigned word_len   = 32;
    localparam int unsigned dump_words = 8;  // words per D or I reply

    localparam logic [7:0] asc_cr = 8'h0d;
    localparam logic [7:0] asc_lf = 8'h0a;
    localparam logic [7:0] asc_sp = 8'h20;

    // upper case command letters
    localparam logic [7:0] cmd_d = 8'h44;
    localparam logic [7:0] cmd_i = 8'h49;
    localparam logic [7:0] cmd_p = 8'h50;
    localparam logic [7:0] cmd_t = 8'h54;

    typedef enum logic [1:0] {
        mode_idle = 2'd0,
        mode_dump = 2'd1,  // D and I
        mode_view = 2'd2   // P and T
    } panel_mode_t;

endpackage

// File: design/dbg_cpu_view.sv
module dbg_cpu_view (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     step,
    output logic                     done,
    output dbg_link_pkg::print_req_t print_req,
    input  logic                     print_ack,
    output logic                     clk_cpu,
    input  dbg_link_pkg::word_t      pc,
    input  dbg_link_pkg::word_t      npc,
    input  dbg_link_pkg::word_t      ir
);
    import dbg_cmd_pkg::*;
    import dbg_link_pkg::*;

    typedef enum logic [2:0] {st_idle, st_pulse, st_settle, st_load, st_wait} state_t;

    state_t     state;
    logic       step_q;
    logic [2:0] idx;  // pc, npc, ir, CR, LF
    word_t      item;

    always_comb begin
        case (idx)
            3'd0:    item = pc;
            3'd1:    item = npc;
            3'd2:    item = ir;
            3'd3:    item = word_t'(asc_cr);
            default: item = word_t'(asc_lf);
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_idle;
            step_q    <= 1'b0;
            idx       <= '0;
            done      <= 1'b0;
            clk_cpu   <= 1'b0;
            print_req <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        step_q <= step;
                        idx    <= '0;
                        if (step) begin
                            clk_cpu <= 1'b1;
                            state   <= st_pulse;
                        end else begin
                            state <= st_load;
                        end
                    end
                end
                st_pulse: begin
                    clk_cpu <= 1'b0;
                    state   <= st_settle;
                end
                st_settle: state <= st_load;  // let the new pc settle
                st_load: begin
                    print_req <= '{req: 1'b1, hex: (idx < 3'd3), data: item};
                    state     <= st_wait;
                end
                default: begin
                    if (print_ack) begin
                        print_req.req <= 1'b0;
                        if (idx == 3'd4) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            idx   <= (step_q && idx == 3'd0) ? 3'd3 : idx + 3'd1;  // T skips npc, ir
                            state <= st_load;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: design/dbg_dispatch.sv
module dbg_dispatch (
    input  logic                     clk,
    input  logic                     rstn,
    output dbg_link_pkg::scan_req_t  scan_req,
    input  dbg_link_pkg::scan_rsp_t  scan_rsp,
    output dbg_link_pkg::print_req_t print_req,
    input  logic                     print_ack,
    input  dbg_link_pkg::scan_req_t  dump_scan_req,
    input  dbg_link_pkg::print_req_t dump_print_req,
    input  dbg_link_pkg::print_req_t view_print_req,
    output logic                     dump_start,
    output logic                     view_start,
    output logic                     mem_sel,
    output logic                     view_step,
    input  logic                     dump_done,
    input  logic                     view_done
);
    import dbg_cmd_pkg::*;

    typedef enum logic [1:0] {st_init, st_req_1st, st_wait} state_t;

    state_t      state;
    panel_mode_t mode;
    logic        first_req;
    logic        start_q;
    logic        child_done;

    assign dump_start = start_q && (mode == mode_dump);
    assign view_start = start_q && (mode == mode_view);
    assign child_done = dump_done || view_done;

    always_comb begin
        scan_req  = '0;
        print_req = '0;
        case (mode)
            mode_dump: begin
                scan_req  = dump_scan_req;
                print_req = dump_print_req;
            end
            mode_view: print_req = view_print_req;
            default:   scan_req = '{req: first_req, hex: 1'b0};
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_init;
            mode      <= mode_idle;
            first_req <= 1'b0;
            start_q   <= 1'b0;
            mem_sel   <= 1'b0;
            view_step <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                st_init: begin
                    first_req <= 1'b1;
                    state     <= st_req_1st;
                end
                st_req_1st: begin
                    if (scan_rsp.ack) begin
                        first_req <= 1'b0;
                        start_q   <= 1'b1;
                        state     <= st_wait;
                        case (scan_rsp.data[7:0])
                            cmd_d: begin
                                mode    <= mode_dump;
                                mem_sel <= 1'b0;
                            end
                            cmd_i: begin
                                mode    <= mode_dump;
                                mem_sel <= 1'b1;
                            end
                            cmd_p: begin
                                mode      <= mode_view;
                                view_step <= 1'b0;
                            end
                            cmd_t: begin
                                mode      <= mode_view;
                                view_step <= 1'b1;
                            end
                            default: begin
                                start_q <= 1'b0;  // read again on an unknown letter
                                state   <= st_init;
                            end
                        endcase
                    end
                end
                default: begin
                    if (child_done) begin
                        mode  <= mode_idle;
                        state <= st_init;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/dbg_link_pkg.sv
package dbg_link_pkg;

    typedef logic [dbg_cmd_pkg::word_len-1:0] word_t;

    typedef struct packed {
        logic req;
        logic hex;  // 0 one char, 1 hex word
    } scan_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;  // word ended on something other than CR
        word_t data;
    } scan_rsp_t;

    typedef struct packed {
        logic  req;
        logic  hex;
        word_t data;
    } print_req_t;

endpackage

// File: design/dbg_mem_dump.sv
module dbg_mem_dump (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     mem_sel,
    output logic                     done,
    output dbg_link_pkg::scan_req_t  scan_req,
    input  dbg_link_pkg::scan_rsp_t  scan_rsp,
    output dbg_link_pkg::print_req_t print_req,
    input  logic                     print_ack,
    output dbg_link_pkg::word_t      addr,
    input  dbg_link_pkg::word_t      dout_dm,
    input  dbg_link_pkg::word_t      dout_im
);
    import dbg_cmd_pkg::*;
    import dbg_link_pkg::*;

    typedef enum logic [1:0] {st_idle, st_arg, st_load, st_wait} state_t;

    state_t state;
    logic   sel_q;  // 1 picks instruction memory
    logic [$clog2(dump_words+2)-1:0] cnt;  // words, then CR, then LF
    word_t  item;
    logic   item_hex;

    always_comb begin
        item_hex = 1'b0;
        item     = word_t'(asc_lf);
        if (cnt < dump_words) begin
            item_hex = 1'b1;
            item     = sel_q ? dout_im : dout_dm;
        end else if (cnt == dump_words) begin
            item = word_t'(asc_cr);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_idle;
            sel_q     <= 1'b0;
            cnt       <= '0;
            addr      <= '0;
            done      <= 1'b0;
            scan_req  <= '0;
            print_req <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        sel_q    <= mem_sel;
                        scan_req <= '{req: 1'b1, hex: 1'b1};
                        state    <= st_arg;
                    end
                end
                st_arg: begin
                    if (scan_rsp.ack) begin
                        scan_req <= '0;
                        if (scan_rsp.err) begin
                            done  <= 1'b1;  // silent exit on a bad argument
                            state <= st_idle;
                        end else begin
                            addr  <= scan_rsp.data;
                            cnt   <= '0;
                            state <= st_load;
                        end
                    end
                end
                st_load: begin
                    print_req <= '{req: 1'b1, hex: item_hex, data: item};
                    state     <= st_wait;
                end
                default: begin
                    if (print_ack) begin
                        print_req.req <= 1'b0;
                        cnt           <= cnt + 1'b1;
                        if (cnt < dump_words)
                            addr <= addr + 1'b1;
                        if (cnt == dump_words + 1) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            state <= st_load;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: design/dbg_panel.sv
module dbg_panel (
    input  logic                clk,
    input  logic                rstn,
    input  logic [7:0]          d_rx,
    input  logic                vld_rx,
    output logic                rdy_rx,
    output logic [7:0]          d_tx,
    output logic                vld_tx,
    input  logic                rdy_tx,
    output logic                clk_cpu,
    input  dbg_link_pkg::word_t pc,
    input  dbg_link_pkg::word_t npc,
    input  dbg_link_pkg::word_t ir,
    output dbg_link_pkg::word_t addr,
    input  dbg_link_pkg::word_t dout_dm,
    input  dbg_link_pkg::word_t dout_im
);
    import dbg_link_pkg::*;

    scan_req_t  scan_req;
    scan_rsp_t  scan_rsp;
    print_req_t print_req;
    logic       print_ack;
    scan_req_t  dump_scan_req;
    print_req_t dump_print_req;
    print_req_t view_print_req;
    logic       dump_start;
    logic       view_start;
    logic       dump_done;
    logic       view_done;
    logic       mem_sel;
    logic       view_step;

    dbg_scan u_scan (
        .clk    (clk),
        .rstn   (rstn),
        .d_rx   (d_rx),
        .vld_rx (vld_rx),
        .rdy_rx (rdy_rx),
        .req    (scan_req),
        .rsp    (scan_rsp)
    );

    dbg_print u_print (
        .clk    (clk),
        .rstn   (rstn),
        .d_tx   (d_tx),
        .vld_tx (vld_tx),
        .rdy_tx (rdy_tx),
        .req    (print_req),
        .ack    (print_ack)
    );

    dbg_dispatch u_dispatch (
        .clk            (clk),
        .rstn           (rstn),
        .scan_req       (scan_req),
        .scan_rsp       (scan_rsp),
        .print_req      (print_req),
        .print_ack      (print_ack),
        .dump_scan_req  (dump_scan_req),
        .dump_print_req (dump_print_req),
        .view_print_req (view_print_req),
        .dump_start     (dump_start),
        .view_start     (view_start),
        .mem_sel        (mem_sel),
        .view_step      (view_step),
        .dump_done      (dump_done),
        .view_done      (view_done)
    );

    dbg_mem_dump u_mem_dump (
        .clk       (clk),
        .rstn      (rstn),
        .start     (dump_start),
        .mem_sel   (mem_sel),
        .done      (dump_done),
        .scan_req  (dump_scan_req),
        .scan_rsp  (scan_rsp),
        .print_req (dump_print_req),
        .print_ack (print_ack),
        .addr      (addr),
        .dout_dm   (dout_dm),
        .dout_im   (dout_im)
    );

    dbg_cpu_view u_cpu_view (
        .clk       (clk),
        .rstn      (rstn),
        .start     (view_start),
        .step      (view_step),
        .done      (view_done),
        .print_req (view_print_req),
        .print_ack (print_ack),
        .clk_cpu   (clk_cpu),
        .pc        (pc),
        .npc       (npc),
        .ir        (ir)
    );

endmodule

// File: design/dbg_print.sv
module dbg_print (
    input  logic                     clk,
    input  logic                     rstn,
    output logic [7:0]               d_tx,
    output logic                     vld_tx,
    input  logic                     rdy_tx,
    input  dbg_link_pkg::print_req_t req,
    output logic                     ack
);
    import dbg_cmd_pkg::*;
    import dbg_link_pkg::*;

    typedef enum logic [1:0] {st_idle, st_send, st_ack} state_t;

    state_t     state;
    word_t      data_q;
    logic       hex_q;
    logic [3:0] cnt;  // byte index where 8 is the trailing space
    logic [3:0] nib;
    logic [7:0] hex_char;
    logic       last;

    assign nib      = data_q[word_len-1 -: 4];
    assign hex_char = (nib < 4'd10) ? {4'h3, nib} : 8'h37 + {4'h0, nib};
    assign d_tx     = !hex_q ? data_q[7:0] : (cnt == 4'd8) ? asc_sp : hex_char;
    assign vld_tx   = (state == st_send);
    assign ack      = (state == st_ack);
    assign last     = !hex_q || (cnt == 4'd8);

    // top nibble is always the next digit out
    always_ff @(posedge clk) begin
        if (state == st_idle && req.req) begin
            data_q <= req.data;
            hex_q  <= req.hex;
        end else if (vld_tx && rdy_tx && hex_q) begin
            data_q <= data_q << 4;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req.req) begin
                        cnt   <= '0;
                        state <= st_send;
                    end
                end
                st_send: begin
                    if (rdy_tx) begin
                        if (last)
                            state <= st_ack;
                        else
                            cnt <= cnt + 4'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: design/dbg_scan.sv
module dbg_scan (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [7:0]              d_rx,
    input  logic                    vld_rx,
    output logic                    rdy_rx,
    input  dbg_link_pkg::scan_req_t req,
    output dbg_link_pkg::scan_rsp_t rsp
);
    import dbg_cmd_pkg::*;
    import dbg_link_pkg::*;

    typedef enum logic {st_idle, st_ack} state_t;

    state_t     state;
    word_t      acc;
    logic       err_q;
    logic       is_hex;
    logic [3:0] nib;
    logic       take;

    assign rdy_rx = req.req && (state == st_idle);
    assign take   = rdy_rx && vld_rx;
    assign rsp    = '{ack: (state == st_ack), err: err_q, data: acc};

    always_comb begin
        is_hex = 1'b1;
        nib    = 4'h0;
        if (d_rx >= 8'h30 && d_rx <= 8'h39) begin       // 0..9
            nib = d_rx[3:0];
        end else if (d_rx >= 8'h41 && d_rx <= 8'h46) begin  // A..F
            nib = d_rx[3:0] + 4'd9;
        end else begin
            is_hex = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
            acc   <= '0;
            err_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (take) begin
                        if (!req.hex) begin
                            acc   <= word_t'(d_rx);
                            err_q <= 1'b0;
                            state <= st_ack;
                        end else if (is_hex) begin
                            acc <= {acc[word_len-5:0], nib};
                        end else begin
                            err_q <= (d_rx != asc_cr);
                            state <= st_ack;
                        end
                    end
                end
                default: begin
                    acc   <= '0;  // next word starts empty
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: list.f
design/dbg_cmd_pkg.sv
design/dbg_link_pkg.sv
design/dbg_scan.sv
design/dbg_print.sv
design/dbg_dispatch.sv
design/dbg_mem_dump.sv
design/dbg_cpu_view.sv
design/dbg_panel.sv
tests/tb_dbg_panel.sv

// File: tests/tb_dbg_panel.sv
module tb_dbg_panel;

    logic        clk;
    logic        rstn;
    logic [7:0]  d_rx;
    logic        vld_rx;
    logic        rdy_rx;
    logic [7:0]  d_tx;
    logic        vld_tx;
    logic        rdy_tx;
    logic        clk_cpu;
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] ir;
    logic [31:0] addr;
    logic [31:0] dout_dm;
    logic [31:0] dout_im;

    logic [31:0] lfsr = 32'h0922_30b7;
    logic [31:0] cpu_pc = 32'h0000_3000;
    logic [31:0] exp_pc = 32'h0000_3000;  // pc as the T commands advance it
    logic        stall_en;
    logic        gap_en;
    logic [7:0]  rx_q[$];
    logic [7:0]  exp_q[$];
    logic        hold_v;
    logic [7:0]  hold_d;
    int          lf_cnt;
    int          hi_cnt;
    int          pulse_cnt;
    int          err_cnt;
    int          err_base;
    int          n_tests;
    int          n_failed;
    string       cur_test;

    dbg_panel UUT (
        .clk     (clk),
        .rstn    (rstn),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .rdy_rx  (rdy_rx),
        .d_tx    (d_tx),
        .vld_tx  (vld_tx),
        .rdy_tx  (rdy_tx),
        .clk_cpu (clk_cpu),
        .pc      (pc),
        .npc     (npc),
        .ir      (ir),
        .addr    (addr),
        .dout_dm (dout_dm),
        .dout_im (dout_im)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] dm_hash(input logic [31:0] a);
        logic [31:0] x;
        x = a ^ 32'h6d2b_79f5;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] im_hash(input logic [31:0] a);
        logic [31:0] x;
        x = a ^ 32'h1b87_3593;
        x = x ^ (x << 7);
        x = x ^ (x >> 9);
        x = x ^ (x << 8);
        return x;
    endfunction

    function automatic logic [7:0] hex_digit(input logic [3:0] n);
        if (n < 4'd10)
            return 8'h30 + n;
        return 8'h41 + (n - 4'd10);
    endfunction

    assign dout_dm = dm_hash(addr);
    assign dout_im = im_hash(addr);
    assign pc      = cpu_pc;
    assign npc     = cpu_pc + 32'd4;
    assign ir      = im_hash(cpu_pc);

    always @(posedge clk_cpu) begin
        cpu_pc    <= cpu_pc + 32'd4;
        pulse_cnt = pulse_cnt + 1;
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
        err_cnt = err_cnt + 1;
    endtask

    // transmit receiver and back-pressure hold check
    always @(posedge clk) begin
        if (clk_cpu)
            hi_cnt = hi_cnt + 1;
        if (hold_v && (vld_tx !== 1'b1 || d_tx !== hold_d))
            report_mismatch("d_tx under back-pressure", hold_d, d_tx);
        hold_v = vld_tx && !rdy_tx;
        hold_d = d_tx;
        if (vld_tx && rdy_tx) begin
            rx_q.push_back(d_tx);
            if (d_tx == 8'h0a)
                lf_cnt = lf_cnt + 1;
        end
    end

    task automatic step_cycle();
        logic [31:0] r;
        @(negedge clk);
        if (stall_en) begin
            take_bits(2, r);
            rdy_tx = (r[1:0] != 2'b00);  // ready three times in four
        end else begin
            rdy_tx = 1'b1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [31:0] r;
        int n;
        if (gap_en) begin
            take_bits(2, r);
            repeat (r[1:0]) step_cycle();
        end
        d_rx   = b;
        vld_rx = 1'b1;
        n      = 0;
        while (!rdy_rx && n < 200) begin
            step_cycle();
            n++;
        end
        if (!rdy_rx) begin
            $display("%s: panel never took byte %h from the receive stream", cur_test, b);
            err_cnt = err_cnt + 1;
        end
        step_cycle();
        vld_rx = 1'b0;
    endtask

    task automatic expect_word(input logic [31:0] w);
        for (int k = 7; k >= 0; k--)
            exp_q.push_back(hex_digit(w[4*k +: 4]));
        exp_q.push_back(8'h20);
    endtask

    task automatic queue_eol();
        exp_q.push_back(8'h0d);
        exp_q.push_back(8'h0a);
    endtask

    task automatic wait_reply(input int base);
        int n;
        n = 0;
        while (lf_cnt == base && n < 3000) begin
            step_cycle();
            n++;
        end
        if (lf_cnt == base) begin
            $display("%s: reply did not end with a line feed in time", cur_test);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic compare_reply();
        logic found;
        found = 1'b0;
        if (rx_q.size() != exp_q.size())
            report_mismatch("reply length", exp_q.size(), rx_q.size());
        for (int k = 0; k < rx_q.size() && k < exp_q.size(); k++) begin
            if (!found && rx_q[k] != exp_q[k]) begin
                report_mismatch("reply byte", exp_q[k], rx_q[k]);
                found = 1'b1;  // first difference only
            end
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic dump_cmd(input logic [7:0] letter);
        logic [31:0] r;
        logic [31:0] a;
        int ndig;
        int base;
        take_bits(3, r);
        ndig = r + 1;
        take_bits(32, a);
        if (ndig < 8)
            a = a & ((32'h1 << (4 * ndig)) - 1);
        base = lf_cnt;
        send_byte(letter);
        for (int k = ndig - 1; k >= 0; k--)
            send_byte(hex_digit(a[4*k +: 4]));
        send_byte(8'h0d);
        for (int k = 0; k < 8; k++)
            expect_word((letter == "I") ? im_hash(a + k) : dm_hash(a + k));
        queue_eol();
        wait_reply(base);
        compare_reply();
    endtask

    task automatic view_cmd(input logic step);
        int base;
        int hi0;
        int pulse0;
        base   = lf_cnt;
        hi0    = hi_cnt;
        pulse0 = pulse_cnt;
        if (step) begin
            exp_pc = exp_pc + 32'd4;
            send_byte("T");
            expect_word(exp_pc);
        end else begin
            send_byte("P");
            expect_word(exp_pc);
            expect_word(exp_pc + 32'd4);
            expect_word(im_hash(exp_pc));
        end
        queue_eol();
        wait_reply(base);
        compare_reply();
        if (hi_cnt - hi0 != int'(step))
            report_mismatch("clk_cpu high cycles", step, hi_cnt - hi0);
        if (pulse_cnt - pulse0 != int'(step))
            report_mismatch("clk_cpu pulses", step, pulse_cnt - pulse0);
    endtask

    // unknown letter, or D with a broken argument
    task automatic ignored_cmd(input logic bad_arg);
        logic [31:0] r;
        logic [31:0] ndig;
        int n;
        if (bad_arg) begin
            send_byte("D");
            take_bits(2, ndig);
            repeat (ndig) begin
                take_bits(4, r);
                send_byte(hex_digit(r[3:0]));
            end
            take_bits(4, r);
            send_byte(8'h47 + r[3:0]);  // G..V
        end else begin
            take_bits(8, r);
            if (r[7:0] == "D" || r[7:0] == "I" || r[7:0] == "P" || r[7:0] == "T")
                r[0] = ~r[0];
            send_byte(r[7:0]);
        end
        // panel reads a new letter again once the command is dropped
        n = 0;
        while (!rdy_rx && n < 200) begin
            step_cycle();
            n++;
        end
        if (!rdy_rx) begin
            $display("%s: panel did not return to reading a command", cur_test);
            err_cnt = err_cnt + 1;
        end
        if (rx_q.size() != 0)
            report_mismatch("bytes after silent command", 0, rx_q.size());
        rx_q.delete();
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = err_cnt;
    endtask

    task automatic end_test();
        n_tests = n_tests + 1;
        if (err_cnt != err_base) begin
            n_failed = n_failed + 1;
            $display("%s: failed", cur_test);
        end else begin
            $display("%s: ok", cur_test);
        end
    endtask

    initial begin
        logic [31:0] r;
        rstn      = 1'b0;
        d_rx      = 8'h00;
        vld_rx    = 1'b0;
        rdy_tx    = 1'b1;
        stall_en  = 1'b0;
        gap_en    = 1'b0;
        hold_v    = 1'b0;
        hold_d    = 8'h00;
        lf_cnt    = 0;
        hi_cnt    = 0;
        pulse_cnt = 0;
        err_cnt   = 0;
        n_tests   = 0;
        n_failed  = 0;

        begin_test("reset");
        repeat (8) begin
            @(negedge clk);
            if (vld_tx !== 1'b0)
                report_mismatch("vld_tx in reset", 0, vld_tx);
            if (rdy_rx !== 1'b0)
                report_mismatch("rdy_rx in reset", 0, rdy_rx);
            if (clk_cpu !== 1'b0)
                report_mismatch("clk_cpu in reset", 0, clk_cpu);
        end
        rstn = 1'b1;
        repeat (12) begin
            step_cycle();
            if (vld_tx !== 1'b0)
                report_mismatch("vld_tx after reset", 0, vld_tx);
            if (clk_cpu !== 1'b0)
                report_mismatch("clk_cpu after reset", 0, clk_cpu);
        end
        if (addr !== 32'h0)
            report_mismatch("addr after reset", 0, addr);
        if (rx_q.size() != 0)
            report_mismatch("bytes before any command", 0, rx_q.size());
        end_test();

        begin_test("dump_dm");
        repeat (4) dump_cmd("D");
        end_test();

        begin_test("dump_im");
        repeat (4) dump_cmd("I");
        end_test();

        begin_test("cpu_view");
        view_cmd(1'b0);
        view_cmd(1'b1);
        view_cmd(1'b0);
        view_cmd(1'b1);
        view_cmd(1'b0);
        end_test();

        begin_test("silent");
        ignored_cmd(1'b0);
        dump_cmd("D");
        ignored_cmd(1'b1);
        view_cmd(1'b0);
        ignored_cmd(1'b1);
        dump_cmd("I");
        end_test();

        begin_test("random_mix");
        stall_en = 1'b1;
        gap_en   = 1'b1;
        for (int c = 0; c < 40; c++) begin
            take_bits(3, r);
            case (r[2:0])
                3'd0, 3'd1: dump_cmd("D");
                3'd2, 3'd3: dump_cmd("I");
                3'd4:       view_cmd(1'b0);
                3'd5:       view_cmd(1'b1);
                3'd6:       ignored_cmd(1'b0);
                default:    ignored_cmd(1'b1);
            endcase
        end
        end_test();

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
